// ==== include/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_XLEN          32
`define RV_IMEM_DEPTH    256
`define RV_DMEM_DEPTH    256
`define RV_UART_TX_ADDR  32'h0000_1000

`define RV_OP_LUI        7'b0110111
`define RV_OP_AUIPC      7'b0010111
`define RV_OP_JAL        7'b1101111
`define RV_OP_JALR       7'b1100111
`define RV_OP_BRANCH     7'b1100011
`define RV_OP_LOAD       7'b0000011
`define RV_OP_STORE      7'b0100011
`define RV_OP_IMM        7'b0010011
`define RV_OP_REG        7'b0110011

`define RV_ALU_ADD       4'd0
`define RV_ALU_SUB       4'd1
`define RV_ALU_SLL       4'd2
`define RV_ALU_SLT       4'd3
`define RV_ALU_SLTU      4'd4
`define RV_ALU_XOR       4'd5
`define RV_ALU_SRL       4'd6
`define RV_ALU_SRA       4'd7
`define RV_ALU_OR        4'd8
`define RV_ALU_AND       4'd9
`define RV_ALU_PASS_B    4'd10

`define RV_SIZE_BYTE     2'd0
`define RV_SIZE_HALF     2'd1
`define RV_SIZE_WORD     2'd2

`endif

// ==== hdl/rv_pkg.sv ====
`default_nettype none
`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;     // data or byte address
    typedef logic [4:0]          reg_addr_t;
    typedef logic [31:0]         inst_t;
    typedef logic [3:0]          alu_op_t;   // codes in rv_params.svh
    typedef logic [1:0]          mem_size_t; // same encoding as funct3[1:0]

    // word index into instruction memory
    typedef logic [$clog2(`RV_IMEM_DEPTH)-1:0] imem_addr_t;

endpackage

`default_nettype wire

// ==== hdl/rv_exec_if.sv ====
`default_nettype none

interface rv_exec_if import rv_pkg::*; ();

    alu_op_t    alu_op;
    logic       src_b_imm;    // immediate instead of rs2
    logic       src_a_pc;     // execute pc instead of rs1
    word_t      imm;
    logic       is_load;
    logic       is_store;
    mem_size_t  mem_size;
    logic       mem_unsigned;
    logic       is_branch;
    logic [2:0] funct3;       // branch condition select

    modport ctrl (
        output alu_op, src_b_imm, src_a_pc, imm, is_load, is_store,
               mem_size, mem_unsigned, is_branch, funct3
    );

    modport alu (
        input alu_op, src_b_imm, src_a_pc, imm, is_branch, funct3
    );

    modport lsu (
        input is_load, is_store, mem_size, mem_unsigned
    );

endinterface

`default_nettype wire

// ==== hdl/rv_control.sv ====
`default_nettype none
`include "rv_params.svh"

module rv_control import rv_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire inst_t     i_inst,
    input  wire            i_branch_taken,
    input  wire word_t     i_jalr_target,
    output word_t          o_pc,
    output word_t          o_pc_ex,
    output word_t          o_link_data,
    output reg_addr_t      o_rs1,
    output reg_addr_t      o_rs2,
    output reg_addr_t      o_rd,
    output logic           o_rd_we,
    rv_exec_if.ctrl        exec
);

    word_t      pc;
    word_t      pc_ex;
    logic       squash;       // fetched word is not executed
    logic       redirect;
    word_t      target;
    logic       dec_jal;
    logic       dec_jalr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_decode = alt ? `RV_ALU_SUB : `RV_ALU_ADD;
            3'b001:  alu_decode = `RV_ALU_SLL;
            3'b010:  alu_decode = `RV_ALU_SLT;
            3'b011:  alu_decode = `RV_ALU_SLTU;
            3'b100:  alu_decode = `RV_ALU_XOR;
            3'b101:  alu_decode = alt ? `RV_ALU_SRA : `RV_ALU_SRL;
            3'b110:  alu_decode = `RV_ALU_OR;
            default: alu_decode = `RV_ALU_AND;
        endcase
    endfunction

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    always_comb begin
        exec.alu_op       = `RV_ALU_ADD;
        exec.src_b_imm    = 1'b0;
        exec.src_a_pc     = 1'b0;
        exec.imm          = imm_i;
        exec.is_load      = 1'b0;
        exec.is_store     = 1'b0;
        exec.mem_size     = funct3[1:0];
        exec.mem_unsigned = funct3[2];
        exec.is_branch    = 1'b0;
        exec.funct3       = funct3;
        dec_jal           = 1'b0;
        dec_jalr          = 1'b0;
        o_rd_we           = 1'b0;
        if (!squash) begin
            case (opcode)
                `RV_OP_LUI: begin
                    exec.alu_op    = `RV_ALU_PASS_B;
                    exec.src_b_imm = 1'b1;
                    exec.imm       = imm_u;
                    o_rd_we        = 1'b1;
                end
                `RV_OP_AUIPC: begin
                    exec.src_a_pc  = 1'b1;
                    exec.src_b_imm = 1'b1;
                    exec.imm       = imm_u;
                    o_rd_we        = 1'b1;
                end
                `RV_OP_JAL: begin
                    dec_jal = 1'b1;
                    o_rd_we = 1'b1;
                end
                `RV_OP_JALR: begin
                    exec.src_b_imm = 1'b1;   // rs1 + imm_i is the target
                    dec_jalr       = 1'b1;
                    o_rd_we        = 1'b1;
                end
                `RV_OP_BRANCH: exec.is_branch = 1'b1;
                `RV_OP_LOAD: begin
                    exec.src_b_imm = 1'b1;
                    exec.is_load   = 1'b1;
                    o_rd_we        = 1'b1;
                end
                `RV_OP_STORE: begin
                    exec.src_b_imm = 1'b1;
                    exec.imm       = imm_s;
                    exec.is_store  = 1'b1;
                end
                `RV_OP_IMM: begin
                    exec.alu_op    = alu_decode(funct3, (funct3 == 3'b101) & i_inst[30]);
                    exec.src_b_imm = 1'b1;
                    o_rd_we        = 1'b1;
                end
                `RV_OP_REG: begin
                    exec.alu_op = alu_decode(funct3, i_inst[30]);
                    o_rd_we     = ~i_inst[25];   // muldiv encodings do nothing
                end
                default: ;   // fence and system
            endcase
        end
    end

    assign redirect = dec_jal | dec_jalr | i_branch_taken;
    assign target   = dec_jal  ? pc_ex + imm_j :
                      dec_jalr ? {i_jalr_target[31:1], 1'b0} :
                                 pc_ex + imm_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            squash <= 1'b1;
        end else begin
            pc     <= redirect ? target : pc + 32'd4;
            squash <= redirect;   // drop the wrong-path fetch
        end
        pc_ex <= pc;
    end

    assign o_pc        = pc;
    assign o_pc_ex     = pc_ex;
    assign o_link_data = pc_ex + 32'd4;
    assign o_rs1       = i_inst[19:15];
    assign o_rs2       = i_inst[24:20];
    assign o_rd        = i_inst[11:7];

endmodule

`default_nettype wire

// ==== hdl/rv_imem.sv ====
`default_nettype none
`include "rv_params.svh"

module rv_imem import rv_pkg::*; (
    input  wire             clk,
    input  wire             i_we,
    input  wire imem_addr_t i_waddr,
    input  wire inst_t      i_wdata,
    input  wire word_t      i_pc,
    output inst_t           o_inst
);

    inst_t      mem [0:`RV_IMEM_DEPTH-1];
    imem_addr_t raddr;

    assign raddr = i_pc[$bits(imem_addr_t)+1:2];   // word index of pc

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;   // program load port
        end
        o_inst <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== hdl/rv_regfile.sv ====
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  wire            clk,
    input  wire reg_addr_t i_rs1,
    input  wire reg_addr_t i_rs2,
    input  wire reg_addr_t i_rd,
    input  wire            i_we,
    input  wire word_t     i_wdata,
    output word_t          o_rs1_data,
    output word_t          o_rs2_data
);

    word_t regs [1:31];   // x0 has no storage

    assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk) begin
        if (i_we && (i_rd != 5'd0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_alu.sv ====
`default_nettype none
`include "rv_params.svh"

module rv_alu import rv_pkg::*; (
    input  wire word_t i_rs1_data,
    input  wire word_t i_rs2_data,
    input  wire word_t i_pc_ex,
    rv_exec_if.alu     exec,
    output word_t      o_result,
    output logic       o_branch_taken
);

    word_t a;
    word_t b;
    logic  cond;

    assign a = exec.src_a_pc  ? i_pc_ex  : i_rs1_data;
    assign b = exec.src_b_imm ? exec.imm : i_rs2_data;

    always_comb begin
        case (exec.alu_op)
            `RV_ALU_ADD:    o_result = a + b;
            `RV_ALU_SUB:    o_result = a - b;
            `RV_ALU_SLL:    o_result = a << b[4:0];
            `RV_ALU_SLT:    o_result = {31'b0, $signed(a) < $signed(b)};
            `RV_ALU_SLTU:   o_result = {31'b0, a < b};
            `RV_ALU_XOR:    o_result = a ^ b;
            `RV_ALU_SRL:    o_result = a >> b[4:0];
            `RV_ALU_SRA:    o_result = $signed(a) >>> b[4:0];
            `RV_ALU_OR:     o_result = a | b;
            `RV_ALU_AND:    o_result = a & b;
            `RV_ALU_PASS_B: o_result = b;   // lui
            default:        o_result = '0;
        endcase
    end

    // branches always compare the two registers
    always_comb begin
        case (exec.funct3)
            3'b000:  cond = (i_rs1_data == i_rs2_data);
            3'b001:  cond = (i_rs1_data != i_rs2_data);
            3'b100:  cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
            3'b101:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            3'b110:  cond = (i_rs1_data <  i_rs2_data);
            3'b111:  cond = (i_rs1_data >= i_rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign o_branch_taken = exec.is_branch & cond;

endmodule

`default_nettype wire

// ==== hdl/rv_lsu.sv ====
`default_nettype none
`include "rv_params.svh"

module rv_lsu import rv_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire word_t i_addr,
    input  wire word_t i_store_data,
    rv_exec_if.lsu     exec,
    output word_t      o_load_data,
    output logic       o_uart_en,
    output logic [7:0] o_uart_tx_data
);

    localparam int IDX_W = $clog2(`RV_DMEM_DEPTH);

    word_t            dmem [0:`RV_DMEM_DEPTH-1];
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic [3:0]       byte_en;
    word_t            wdata;
    word_t            rword;
    word_t            lane;
    logic             tx_hit;

    assign idx      = i_addr[IDX_W+1:2];
    assign in_range = (i_addr >> (IDX_W + 2)) == '0;   // tx address falls outside

    // replicate the store data so every enabled lane sees it
    always_comb begin
        case (exec.mem_size)
            `RV_SIZE_BYTE: begin
                byte_en = 4'b0001 << i_addr[1:0];
                wdata   = {4{i_store_data[7:0]}};
            end
            `RV_SIZE_HALF: begin
                byte_en = 4'b0011 << {i_addr[1], 1'b0};
                wdata   = {2{i_store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wdata   = i_store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (exec.is_store && in_range) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    dmem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    assign rword = dmem[idx];
    assign lane  = rword >> {i_addr[1:0], 3'b000};   // addressed lane to bit 0

    always_comb begin
        o_load_data = '0;
        if (exec.is_load) begin
            case (exec.mem_size)
                `RV_SIZE_BYTE: o_load_data = {{24{lane[7] & ~exec.mem_unsigned}}, lane[7:0]};
                `RV_SIZE_HALF: o_load_data = {{16{lane[15] & ~exec.mem_unsigned}}, lane[15:0]};
                default:       o_load_data = rword;
            endcase
        end
    end

    assign tx_hit = exec.is_store && (exec.mem_size == `RV_SIZE_BYTE) &&
                    (i_addr == `RV_UART_TX_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            o_uart_en      <= 1'b0;
            o_uart_tx_data <= 8'h00;
        end else begin
            o_uart_en      <= tx_hit;
            o_uart_tx_data <= tx_hit ? i_store_data[7:0] : 8'h00;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`default_nettype none
`include "rv_params.svh"

module rv_core import rv_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             i_imem_we,
    input  wire imem_addr_t i_imem_addr,
    input  wire inst_t      i_imem_data,
    output logic            o_uart_en,
    output logic [7:0]      o_uart_tx_data
);

    rv_exec_if exec_if();

    inst_t     inst;
    word_t     pc;
    word_t     pc_ex;
    word_t     link_data;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    word_t     load_data;
    word_t     wb_data;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      rd_we;
    logic      branch_taken;
    logic      link_sel;

    rv_control u_control (
        .clk            (clk),
        .reset          (reset),
        .i_inst         (inst),
        .i_branch_taken (branch_taken),
        .i_jalr_target  (alu_result),
        .o_pc           (pc),
        .o_pc_ex        (pc_ex),
        .o_link_data    (link_data),
        .o_rs1          (rs1),
        .o_rs2          (rs2),
        .o_rd           (rd),
        .o_rd_we        (rd_we),
        .exec           (exec_if)
    );

    rv_imem u_imem (
        .clk     (clk),
        .i_we    (i_imem_we),
        .i_waddr (i_imem_addr),
        .i_wdata (i_imem_data),
        .i_pc    (pc),
        .o_inst  (inst)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (rd),
        .i_we       (rd_we),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_pc_ex        (pc_ex),
        .exec           (exec_if),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    rv_lsu u_lsu (
        .clk            (clk),
        .reset          (reset),
        .i_addr         (alu_result),
        .i_store_data   (rs2_data),
        .exec           (exec_if),
        .o_load_data    (load_data),
        .o_uart_en      (o_uart_en),
        .o_uart_tx_data (o_uart_tx_data)
    );

    // jal and jalr write the return address
    assign link_sel = (inst[6:0] == `RV_OP_JAL) || (inst[6:0] == `RV_OP_JALR);
    assign wb_data  = link_sel        ? link_data :
                      exec_if.is_load ? load_data :
                                        alu_result;

endmodule

`default_nettype wire

// ==== dv/rv_core_checker.sv ====
`default_nettype none

module rv_core_checker (
    input wire       clk,
    input wire       reset,
    input wire       i_uart_en,
    input wire [7:0] i_uart_tx_data
);

    timeunit 1ns;
    timeprecision 1ps;

    uart_quiet_in_reset: assert property (@(posedge clk) reset |=> !i_uart_en)
        else $error("transmit strobe while reset is held");

    // strobe lasts one cycle only
    strobe_single_cycle: assert property (
        @(posedge clk) disable iff (reset) i_uart_en |=> !i_uart_en
    ) else $error("transmit strobe high two cycles in a row");

    data_zero_when_idle: assert property (
        @(posedge clk) disable iff (reset) !i_uart_en |-> (i_uart_tx_data == 8'h00)
    ) else $error("transmit data not zero outside a strobe");

endmodule

bind rv_core rv_core_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .i_uart_en      (o_uart_en),
    .i_uart_tx_data (o_uart_tx_data)
);

`default_nettype wire

// ==== dv/tb_rv_core.sv ====
`default_nettype none
`include "rv_params.svh"

module tb_rv_core import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TX_BASE        = 31;   // holds the transmit address
    localparam int TMP            = 30;   // scratch for byte shifts
    localparam int STROBE_TIMEOUT = 200;
    localparam int QUIET_CYCLES   = 50;

    logic       clk;
    logic       reset;
    logic       imem_we;
    imem_addr_t imem_addr;
    inst_t      imem_data;
    logic       uart_en;
    logic [7:0] uart_tx_data;

    // program table, flattened
    logic [31:0] prog_words [$];
    int          prog_first [$];
    int          prog_count [$];
    logic [7:0]  exp_bytes [$];
    int          exp_first [$];
    int          exp_count [$];

    rv_core DUT (
        .clk            (clk),
        .reset          (reset),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .o_uart_en      (uart_en),
        .o_uart_tx_data (uart_tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] f3, input int rs2,
                                           input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1,
                                           input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OP_JAL};
    endfunction

    function automatic int cur_pc();
        return 4 * (prog_words.size() - prog_first[$]);
    endfunction

    task automatic add_word(input logic [31:0] w);
        prog_words.push_back(w);
    endtask

    task automatic start_program();
        prog_first.push_back(prog_words.size());
        exp_first.push_back(exp_bytes.size());
        add_word(u_type(`RV_OP_LUI, TX_BASE, 1));   // 0x1000
    endtask

    task automatic close_program();
        add_word(j_type(0, 0));   // spin here
        prog_count.push_back(prog_words.size() - prog_first[$]);
        exp_count.push_back(exp_bytes.size() - exp_first[$]);
    endtask

    task automatic send_reg(input int rs, input logic [7:0] exp);
        add_word(s_type(3'b000, rs, TX_BASE, 0));
        exp_bytes.push_back(exp);
    endtask

    task automatic run_and_send(input logic [31:0] w, input int rd, input logic [7:0] exp);
        add_word(w);
        send_reg(rd, exp);
    endtask

    // all four bytes, low first; srli keeps the sb strobes apart
    task automatic send_word(input int rs, input logic [31:0] exp);
        send_reg(rs, exp[7:0]);
        for (int k = 1; k < 4; k++) begin
            add_word(i_type(`RV_OP_IMM, 3'b101, TMP, rs, 8 * k));
            send_reg(TMP, exp[8*k +: 8]);
        end
    endtask

    task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
                               input bit taken, input int k);
        add_word(i_type(`RV_OP_IMM, 3'b000, 5, 0, 64 + k));
        add_word(b_type(f3, rs1, rs2, 8));
        add_word(i_type(`RV_OP_IMM, 3'b000, 5, 0, 96 + k));   // fall-through only
        send_reg(5, taken ? 8'(64 + k) : 8'(96 + k));
    endtask

    task automatic load_case(input logic [2:0] f3, input int off, input logic [31:0] exp);
        add_word(i_type(`RV_OP_LOAD, f3, 2, 0, off));
        send_word(2, exp);
    endtask

    task automatic build_programs();
        int pc;
        // x1 = 100, x2 = -7, x11 = 3, x13 = 28
        start_program();
        add_word(i_type(`RV_OP_IMM, 3'b000, 1, 0, 100));
        add_word(i_type(`RV_OP_IMM, 3'b000, 2, 0, -7));
        add_word(i_type(`RV_OP_IMM, 3'b000, 11, 0, 3));
        add_word(i_type(`RV_OP_IMM, 3'b000, 13, 0, 28));
        run_and_send(r_type(7'h00, 3'b000, 3, 1, 2), 3, 8'h5d);
        run_and_send(r_type(7'h20, 3'b000, 3, 1, 2), 3, 8'h6b);
        run_and_send(r_type(7'h00, 3'b001, 3, 1, 11), 3, 8'h20);
        run_and_send(r_type(7'h00, 3'b010, 3, 2, 1), 3, 8'h01);
        run_and_send(r_type(7'h00, 3'b010, 3, 1, 2), 3, 8'h00);
        run_and_send(r_type(7'h00, 3'b011, 3, 2, 1), 3, 8'h00);
        run_and_send(r_type(7'h00, 3'b011, 3, 1, 2), 3, 8'h01);
        run_and_send(r_type(7'h00, 3'b100, 3, 1, 2), 3, 8'h9d);
        run_and_send(r_type(7'h00, 3'b101, 3, 2, 13), 3, 8'h0f);
        run_and_send(r_type(7'h20, 3'b101, 3, 2, 13), 3, 8'hff);
        run_and_send(r_type(7'h00, 3'b110, 3, 1, 2), 3, 8'hfd);
        run_and_send(r_type(7'h00, 3'b111, 3, 1, 2), 3, 8'h60);
        run_and_send(i_type(`RV_OP_IMM, 3'b000, 3, 1, -1), 3, 8'h63);
        run_and_send(i_type(`RV_OP_IMM, 3'b010, 3, 2, -6), 3, 8'h01);
        run_and_send(i_type(`RV_OP_IMM, 3'b011, 3, 1, -1), 3, 8'h01);
        run_and_send(i_type(`RV_OP_IMM, 3'b100, 3, 1, 'hff), 3, 8'h9b);
        run_and_send(i_type(`RV_OP_IMM, 3'b110, 3, 1, 'h0f), 3, 8'h6f);
        run_and_send(i_type(`RV_OP_IMM, 3'b111, 3, 1, 'h3c), 3, 8'h24);
        run_and_send(i_type(`RV_OP_IMM, 3'b001, 3, 1, 2), 3, 8'h90);
        run_and_send(i_type(`RV_OP_IMM, 3'b101, 3, 2, 25), 3, 8'h7f);
        run_and_send(i_type(`RV_OP_IMM, 3'b101, 3, 2, 'h401), 3, 8'hfc);   // srai 1
        run_and_send(i_type(`RV_OP_IMM, 3'b000, 0, 0, 55), 0, 8'h00);
        run_and_send(r_type(7'h00, 3'b000, 0, 1, 1), 0, 8'h00);
        close_program();

        // branches on x1 = 5, x2 = -3, x3 = 5
        start_program();
        add_word(i_type(`RV_OP_IMM, 3'b000, 1, 0, 5));
        add_word(i_type(`RV_OP_IMM, 3'b000, 2, 0, -3));
        add_word(i_type(`RV_OP_IMM, 3'b000, 3, 0, 5));
        branch_case(3'b000, 1, 3, 1'b1, 0);
        branch_case(3'b000, 1, 2, 1'b0, 1);
        branch_case(3'b001, 1, 2, 1'b1, 2);
        branch_case(3'b001, 1, 3, 1'b0, 3);
        branch_case(3'b100, 2, 1, 1'b1, 4);
        branch_case(3'b100, 1, 2, 1'b0, 5);
        branch_case(3'b101, 1, 2, 1'b1, 6);
        branch_case(3'b101, 2, 1, 1'b0, 7);
        branch_case(3'b110, 1, 2, 1'b1, 8);
        branch_case(3'b110, 2, 1, 1'b0, 9);
        branch_case(3'b111, 2, 1, 1'b1, 10);
        branch_case(3'b111, 1, 2, 1'b0, 11);
        branch_case(3'b101, 1, 3, 1'b1, 12);
        add_word(i_type(`RV_OP_IMM, 3'b000, 7, 0, 'h11));
        pc = cur_pc();
        add_word(j_type(6, 8));
        add_word(i_type(`RV_OP_IMM, 3'b000, 7, 0, 'h22));   // skipped by jal
        send_reg(6, 8'(pc + 4));
        pc = cur_pc();
        add_word(u_type(`RV_OP_AUIPC, 8, 0));
        add_word(i_type(`RV_OP_JALR, 3'b000, 9, 8, 13));   // odd target, bit 0 dropped
        add_word(i_type(`RV_OP_IMM, 3'b000, 7, 0, 'h33));   // skipped by jalr
        add_word(u_type(`RV_OP_AUIPC, 10, 0));   // jalr lands here
        send_reg(9, 8'(pc + 8));
        add_word(i_type(`RV_OP_IMM, 3'b000, 0, 0, 0));
        send_reg(10, 8'(pc + 12));
        add_word(i_type(`RV_OP_IMM, 3'b000, 0, 0, 0));
        send_reg(7, 8'h11);
        close_program();

        // word 0x64f38102 at address 8
        start_program();
        add_word(u_type(`RV_OP_LUI, 1, 'h64f38));
        add_word(i_type(`RV_OP_IMM, 3'b000, 1, 1, 'h102));
        add_word(s_type(3'b010, 1, 0, 8));
        add_word(i_type(`RV_OP_IMM, 3'b000, 4, 0, 'h5a));
        add_word(i_type(`RV_OP_IMM, 3'b000, 6, 0, 'h7bc));
        load_case(3'b000, 8, 32'h0000_0002);
        load_case(3'b000, 9, 32'hffff_ff81);
        load_case(3'b000, 10, 32'hffff_fff3);
        load_case(3'b000, 11, 32'h0000_0064);
        load_case(3'b100, 8, 32'h0000_0002);
        load_case(3'b100, 9, 32'h0000_0081);
        load_case(3'b100, 10, 32'h0000_00f3);
        load_case(3'b100, 11, 32'h0000_0064);
        load_case(3'b001, 8, 32'hffff_8102);
        load_case(3'b001, 10, 32'h0000_64f3);
        load_case(3'b101, 8, 32'h0000_8102);
        load_case(3'b101, 10, 32'h0000_64f3);
        load_case(3'b010, 8, 32'h64f3_8102);
        add_word(s_type(3'b010, 1, 0, 12));
        add_word(s_type(3'b000, 4, 0, 14));
        load_case(3'b010, 12, 32'h645a_8102);
        add_word(s_type(3'b010, 1, 0, 16));
        add_word(s_type(3'b001, 6, 0, 18));
        load_case(3'b010, 16, 32'h07bc_8102);
        add_word(s_type(3'b010, 1, 0, 20));
        add_word(s_type(3'b001, 6, 0, 20));
        load_case(3'b010, 20, 32'h64f3_07bc);
        add_word(s_type(3'b010, 1, 0, 24));
        add_word(s_type(3'b000, 4, 0, 27));
        load_case(3'b010, 24, 32'h5af3_8102);
        close_program();

        // upper immediates and x0
        start_program();
        add_word(u_type(`RV_OP_LUI, 1, 'habcde));
        send_word(1, 32'habcd_e000);
        pc = cur_pc();
        add_word(u_type(`RV_OP_AUIPC, 2, 'h12345));
        send_word(2, 32'h1234_5000 + 32'(pc));
        pc = cur_pc();
        add_word(u_type(`RV_OP_AUIPC, 2, 'hfffff));
        send_word(2, 32'hffff_f000 + 32'(pc));
        add_word(u_type(`RV_OP_LUI, 0, 'h12345));
        send_word(0, 32'h0000_0000);
        close_program();
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic load_program(input int p);
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        for (int i = 0; i < prog_count[p]; i++) begin
            imem_we   = 1'b1;
            imem_addr = imem_addr_t'(i);
            imem_data = prog_words[prog_first[p] + i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        reset   = 1'b0;
    endtask

    task automatic wait_strobe();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < STROBE_TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = uart_en;
        end
        if (!seen) begin
            fail_run("timed out waiting for a transmit strobe");
        end
    endtask

    task automatic check_quiet();
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            if (uart_en) begin
                fail_run("a transmit strobe arrived after the last expected byte");
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        build_programs();
        for (int p = 0; p < prog_first.size(); p++) begin
            load_program(p);
            for (int b = 0; b < exp_count[p]; b++) begin
                wait_strobe();
                check_value($sformatf("o_uart_tx_data (program %0d byte %0d)", p, b),
                            {24'h0, uart_tx_data}, {24'h0, exp_bytes[exp_first[p] + b]});
            end
            check_quiet();
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/rv_exec_if.sv
hdl/rv_control.sv
hdl/rv_imem.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
dv/rv_core_checker.sv
dv/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build the core with its testbench in Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_core -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
